// File: logic/dccm_config.svh
`ifndef DCCM_CONFIG_SVH
`define DCCM_CONFIG_SVH

// memory geometry
`define DCCM_ADDR_BITS   16   // byte address width
`define DCCM_DATA_WIDTH  32   // data bits per bank word
`define DCCM_ECC_WIDTH   7    // check bits per bank word
`define DCCM_BYTES       4    // bytes per bank word

// bank select bit, bits below it are the byte offset
`define DCCM_BANK_LSB    2

// access size codes
`define SIZE_BYTE        2'd0
`define SIZE_HALF        2'd1
`define SIZE_WORD        2'd2

`endif

// File: logic/dccm_pkg.sv
`include "dccm_config.svh"

package dccm_pkg;

   typedef logic [`DCCM_ADDR_BITS-1:0]  dccm_addr_t;     // byte address
   typedef logic [`DCCM_DATA_WIDTH-1:0] dccm_data_t;     // one bank word
   typedef logic [`DCCM_ECC_WIDTH-1:0]  dccm_ecc_t;      // its check bits

   // stored word, check bits sit above the data
   typedef logic [`DCCM_ECC_WIDTH+`DCCM_DATA_WIDTH-1:0] dccm_fdata_t;

   typedef logic [`DCCM_BYTES-1:0]      dccm_byteen_t;   // byte enables per bank
   typedef logic [1:0]                  access_size_t;   // see SIZE_* codes

endpackage

// File: logic/dccm_fix_if.sv
`timescale 1ns/1ps

// pending ECC correction, one cycle after the load left r
interface dccm_fix_if;

   logic                   fix_pending;   // write-back wanted this cycle
   logic                   fix_lo;        // lo-address word is corrected
   logic                   fix_hi;        // hi-address word is corrected
   dccm_pkg::dccm_addr_t   fix_addr_lo;
   dccm_pkg::dccm_addr_t   fix_addr_hi;
   dccm_pkg::dccm_fdata_t  fix_word_lo;   // corrected data with new check bits
   dccm_pkg::dccm_fdata_t  fix_word_hi;

   modport tracker (
      output fix_pending, fix_lo, fix_hi,
      output fix_addr_lo, fix_addr_hi, fix_word_lo, fix_word_hi
   );

   modport arb (
      input fix_pending, fix_lo, fix_hi,
      input fix_addr_lo, fix_addr_hi, fix_word_lo, fix_word_hi
   );

endinterface

// File: logic/dccm_rd_pipe.sv
`timescale 1ns/1ps
`include "dccm_config.svh"

module dccm_rd_pipe (
   input  logic                      clk,
   input  logic                      reset,

   input  logic                      valid_d,
   input  logic                      load_d,
   input  logic                      store_d,
   input  dccm_pkg::access_size_t    size_d,
   input  dccm_pkg::dccm_addr_t      addr_d,
   input  dccm_pkg::dccm_addr_t      end_addr_d,
   input  logic                      in_dccm_d,

   input  dccm_pkg::dccm_fdata_t     rd_word_lo,        // memory answer in m
   input  dccm_pkg::dccm_fdata_t     rd_word_hi,

   input  dccm_pkg::dccm_data_t      fwd_data_lo_m,
   input  dccm_pkg::dccm_data_t      fwd_data_hi_m,
   input  dccm_pkg::dccm_byteen_t    fwd_byteen_lo_m,
   input  dccm_pkg::dccm_byteen_t    fwd_byteen_hi_m,

   input  dccm_pkg::dccm_addr_t      addr_r,
   input  dccm_pkg::dccm_data_t      sec_data_lo_r,
   input  dccm_pkg::dccm_data_t      sec_data_hi_r,

   output logic                      rden_d,
   output logic                      rden_r,
   output dccm_pkg::dccm_addr_t      rd_addr_lo,
   output dccm_pkg::dccm_addr_t      rd_addr_hi,
   output dccm_pkg::dccm_data_t      ld_data_r,
   output dccm_pkg::dccm_data_t      ld_data_corr_r
);

   logic                    aligned_word_d;
   logic                    rden_m;
   dccm_pkg::dccm_data_t    rdata_lo_r;
   dccm_pkg::dccm_data_t    rdata_hi_r;
   dccm_pkg::dccm_data_t    fwd_data_lo_r;
   dccm_pkg::dccm_data_t    fwd_data_hi_r;
   dccm_pkg::dccm_byteen_t  fwd_byteen_lo_r;
   dccm_pkg::dccm_byteen_t  fwd_byteen_hi_r;

   // byte-wise forwarding merge over both banks, then right justify
   function automatic dccm_pkg::dccm_data_t merge_shift(
      input logic [2*`DCCM_DATA_WIDTH-1:0] mem_dw,
      input logic [2*`DCCM_DATA_WIDTH-1:0] fwd_dw,
      input logic [2*`DCCM_BYTES-1:0]      byteen,
      input logic [`DCCM_BANK_LSB-1:0]     offset
   );
      logic [2*`DCCM_DATA_WIDTH-1:0] merged;
      logic [2*`DCCM_DATA_WIDTH-1:0] shifted;
      for (int i = 0; i < 2*`DCCM_BYTES; i++) begin
         merged[8*i +: 8] = byteen[i] ? fwd_dw[8*i +: 8] : mem_dw[8*i +: 8];
      end
      shifted = merged >> {offset, 3'b000};   // 8 x byte offset
      return shifted[`DCCM_DATA_WIDTH-1:0];
   endfunction

   // an aligned word store rewrites the whole word and its check bits
   assign aligned_word_d = (size_d == `SIZE_WORD) &&
                           (addr_d[`DCCM_BANK_LSB-1:0] == '0);

   assign rden_d = valid_d & in_dccm_d & (load_d | (store_d & ~aligned_word_d));

   assign rd_addr_lo = addr_d;       // lo bank at start address
   assign rd_addr_hi = end_addr_d;   // hi bank at end address

   always_ff @(posedge clk) begin
      if (reset) begin
         rden_m <= 1'b0;
         rden_r <= 1'b0;
      end else begin
         rden_m <= rden_d;
         rden_r <= rden_m;
      end
   end

   // raw bank data, held until the next read
   always_ff @(posedge clk) begin
      if (rden_m) begin
         rdata_lo_r <= rd_word_lo[`DCCM_DATA_WIDTH-1:0];
         rdata_hi_r <= rd_word_hi[`DCCM_DATA_WIDTH-1:0];
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_lo_r   <= fwd_data_lo_m;
      fwd_data_hi_r   <= fwd_data_hi_m;
      fwd_byteen_lo_r <= fwd_byteen_lo_m;
      fwd_byteen_hi_r <= fwd_byteen_hi_m;
   end

   assign ld_data_r = merge_shift({rdata_hi_r, rdata_lo_r},
                                  {fwd_data_hi_r, fwd_data_lo_r},
                                  {fwd_byteen_hi_r, fwd_byteen_lo_r},
                                  addr_r[`DCCM_BANK_LSB-1:0]);

   assign ld_data_corr_r = merge_shift({sec_data_hi_r, sec_data_lo_r},
                                       {fwd_data_hi_r, fwd_data_lo_r},
                                       {fwd_byteen_hi_r, fwd_byteen_lo_r},
                                       addr_r[`DCCM_BANK_LSB-1:0]);

endmodule

// File: logic/dccm_sec_tracker.sv
`timescale 1ns/1ps

module dccm_sec_tracker (
   input  logic                    clk,
   input  logic                    reset,

   input  logic                    load_r,
   input  logic                    dma_r,
   input  logic                    commit_r,
   input  logic                    raw_fwd_lo_r,     // bank fully forwarded
   input  logic                    raw_fwd_hi_r,
   input  logic                    single_err_lo_r,
   input  logic                    single_err_hi_r,
   input  logic                    double_err_r,

   input  dccm_pkg::dccm_addr_t    addr_r,
   input  dccm_pkg::dccm_addr_t    end_addr_r,
   input  dccm_pkg::dccm_data_t    sec_data_lo_r,
   input  dccm_pkg::dccm_data_t    sec_data_hi_r,
   input  dccm_pkg::dccm_ecc_t     sec_ecc_lo_r,
   input  dccm_pkg::dccm_ecc_t     sec_ecc_hi_r,

   output logic                    single_err_r,
   dccm_fix_if.tracker             fix
);

   logic ld_err_lo;
   logic ld_err_hi;
   logic fix_take;   // correction goes to the write port next cycle

   // forwarded bytes never came from the bad word
   assign ld_err_lo = load_r & single_err_lo_r & ~raw_fwd_lo_r;
   assign ld_err_hi = load_r & single_err_hi_r & ~raw_fwd_hi_r;

   assign single_err_r = (ld_err_lo | ld_err_hi) & ~double_err_r;

   // only a load that leaves the pipe may write back
   assign fix_take = single_err_r & (commit_r | dma_r);

   always_ff @(posedge clk) begin
      if (reset) begin
         fix.fix_pending <= 1'b0;
         fix.fix_lo      <= 1'b0;
         fix.fix_hi      <= 1'b0;
      end else begin
         fix.fix_pending <= fix_take;
         fix.fix_lo      <= fix_take & ld_err_lo;
         fix.fix_hi      <= fix_take & ld_err_hi;
      end
   end

   always_ff @(posedge clk) begin
      if (fix_take) begin
         fix.fix_addr_lo <= addr_r;
         fix.fix_addr_hi <= end_addr_r;
         fix.fix_word_lo <= {sec_ecc_lo_r, sec_data_lo_r};
         fix.fix_word_hi <= {sec_ecc_hi_r, sec_data_hi_r};
      end
   end

endmodule

// File: logic/dccm_wr_arb.sv
`timescale 1ns/1ps
`include "dccm_config.svh"

module dccm_wr_arb (
   input  logic                    rden_d,
   dccm_fix_if.arb                 fix,

   input  logic                    dma_wen,
   input  dccm_pkg::dccm_fdata_t   dma_word_lo,
   input  dccm_pkg::dccm_fdata_t   dma_word_hi,
   input  dccm_pkg::dccm_addr_t    addr_d,       // DMA writes use the d addresses
   input  dccm_pkg::dccm_addr_t    end_addr_d,

   input  logic                    stbuf_req,
   input  dccm_pkg::dccm_addr_t    stbuf_addr,   // word aligned
   input  dccm_pkg::dccm_fdata_t   stbuf_word,

   output logic                    stbuf_commit,
   output logic                    wren,
   output dccm_pkg::dccm_addr_t    wr_addr_lo,
   output dccm_pkg::dccm_addr_t    wr_addr_hi,
   output dccm_pkg::dccm_fdata_t   wr_word_lo,
   output dccm_pkg::dccm_fdata_t   wr_word_hi
);

   logic port_idle;
   logic bank_free;   // store bank untouched by the d-stage read

   assign port_idle = ~(rden_d | dma_wen | fix.fix_pending);

   assign bank_free = (stbuf_addr[`DCCM_BANK_LSB] != addr_d[`DCCM_BANK_LSB]) &&
                      (stbuf_addr[`DCCM_BANK_LSB] != end_addr_d[`DCCM_BANK_LSB]);

   // a read leaves the other bank open, writers never share the port
   assign stbuf_commit = stbuf_req &
                         (port_idle |
                          (rden_d & bank_free & ~dma_wen & ~fix.fix_pending));

   assign wren = fix.fix_pending | dma_wen | stbuf_commit;

   always_comb begin
      if (fix.fix_pending) begin
         // single-bank fix drives its record onto both halves
         wr_addr_lo = fix.fix_lo ? fix.fix_addr_lo : fix.fix_addr_hi;
         wr_addr_hi = fix.fix_hi ? fix.fix_addr_hi : fix.fix_addr_lo;
         wr_word_lo = fix.fix_lo ? fix.fix_word_lo : fix.fix_word_hi;
         wr_word_hi = fix.fix_hi ? fix.fix_word_hi : fix.fix_word_lo;
      end else if (dma_wen) begin
         wr_addr_lo = addr_d;
         wr_addr_hi = end_addr_d;
         wr_word_lo = dma_word_lo;
         wr_word_hi = dma_word_hi;
      end else begin
         wr_addr_lo = stbuf_addr;   // same word on both, bank bit picks one
         wr_addr_hi = stbuf_addr;
         wr_word_lo = stbuf_word;
         wr_word_hi = stbuf_word;
      end
   end

endmodule

// File: logic/dccm_ctl.sv
`timescale 1ns/1ps

module dccm_ctl (
   input  logic                      clk,
   input  logic                      reset,

   // d stage
   input  logic                      valid_d,
   input  logic                      load_d,
   input  logic                      store_d,
   input  dccm_pkg::access_size_t    size_d,
   input  dccm_pkg::dccm_addr_t      addr_d,
   input  dccm_pkg::dccm_addr_t      end_addr_d,
   input  logic                      in_dccm_d,

   // m stage, store-buffer forwarding
   input  dccm_pkg::dccm_data_t      fwd_data_lo_m,
   input  dccm_pkg::dccm_data_t      fwd_data_hi_m,
   input  dccm_pkg::dccm_byteen_t    fwd_byteen_lo_m,
   input  dccm_pkg::dccm_byteen_t    fwd_byteen_hi_m,

   // r stage, pipe state and ECC unit results
   input  logic                      load_r,
   input  logic                      dma_r,
   input  logic                      commit_r,
   input  logic                      raw_fwd_lo_r,
   input  logic                      raw_fwd_hi_r,
   input  logic                      single_err_lo_r,
   input  logic                      single_err_hi_r,
   input  logic                      double_err_r,
   input  dccm_pkg::dccm_addr_t      addr_r,
   input  dccm_pkg::dccm_addr_t      end_addr_r,
   input  dccm_pkg::dccm_data_t      sec_data_lo_r,
   input  dccm_pkg::dccm_data_t      sec_data_hi_r,
   input  dccm_pkg::dccm_ecc_t       sec_ecc_lo_r,
   input  dccm_pkg::dccm_ecc_t       sec_ecc_hi_r,

   // DMA and store-buffer writers
   input  logic                      dma_wen,
   input  dccm_pkg::dccm_fdata_t     dma_word_lo,
   input  dccm_pkg::dccm_fdata_t     dma_word_hi,
   input  logic                      stbuf_req,
   input  dccm_pkg::dccm_addr_t      stbuf_addr,
   input  dccm_pkg::dccm_fdata_t     stbuf_word,
   output logic                      stbuf_commit,

   // memory ports
   output logic                      dccm_rden,
   output dccm_pkg::dccm_addr_t      dccm_rd_addr_lo,
   output dccm_pkg::dccm_addr_t      dccm_rd_addr_hi,
   input  dccm_pkg::dccm_fdata_t     rd_word_lo,
   input  dccm_pkg::dccm_fdata_t     rd_word_hi,
   output logic                      dccm_wren,
   output dccm_pkg::dccm_addr_t      dccm_wr_addr_lo,
   output dccm_pkg::dccm_addr_t      dccm_wr_addr_hi,
   output dccm_pkg::dccm_fdata_t     dccm_wr_word_lo,
   output dccm_pkg::dccm_fdata_t     dccm_wr_word_hi,

   // load results
   output logic                      rden_r,
   output dccm_pkg::dccm_data_t      ld_data_r,
   output dccm_pkg::dccm_data_t      ld_data_corr_r,
   output logic                      single_err_r
);

   logic rden_d;   // also blocks store-buffer bank conflicts

   dccm_fix_if fix_bus ();

   dccm_rd_pipe i_rd_pipe (
      .clk             (clk),
      .reset           (reset),
      .valid_d         (valid_d),
      .load_d          (load_d),
      .store_d         (store_d),
      .size_d          (size_d),
      .addr_d          (addr_d),
      .end_addr_d      (end_addr_d),
      .in_dccm_d       (in_dccm_d),
      .rd_word_lo      (rd_word_lo),
      .rd_word_hi      (rd_word_hi),
      .fwd_data_lo_m   (fwd_data_lo_m),
      .fwd_data_hi_m   (fwd_data_hi_m),
      .fwd_byteen_lo_m (fwd_byteen_lo_m),
      .fwd_byteen_hi_m (fwd_byteen_hi_m),
      .addr_r          (addr_r),
      .sec_data_lo_r   (sec_data_lo_r),
      .sec_data_hi_r   (sec_data_hi_r),
      .rden_d          (rden_d),
      .rden_r          (rden_r),
      .rd_addr_lo      (dccm_rd_addr_lo),
      .rd_addr_hi      (dccm_rd_addr_hi),
      .ld_data_r       (ld_data_r),
      .ld_data_corr_r  (ld_data_corr_r)
   );

   assign dccm_rden = rden_d;

   dccm_sec_tracker i_sec_tracker (
      .clk             (clk),
      .reset           (reset),
      .load_r          (load_r),
      .dma_r           (dma_r),
      .commit_r        (commit_r),
      .raw_fwd_lo_r    (raw_fwd_lo_r),
      .raw_fwd_hi_r    (raw_fwd_hi_r),
      .single_err_lo_r (single_err_lo_r),
      .single_err_hi_r (single_err_hi_r),
      .double_err_r    (double_err_r),
      .addr_r          (addr_r),
      .end_addr_r      (end_addr_r),
      .sec_data_lo_r   (sec_data_lo_r),
      .sec_data_hi_r   (sec_data_hi_r),
      .sec_ecc_lo_r    (sec_ecc_lo_r),
      .sec_ecc_hi_r    (sec_ecc_hi_r),
      .single_err_r    (single_err_r),
      .fix             (fix_bus.tracker)
   );

   dccm_wr_arb i_wr_arb (
      .rden_d          (rden_d),
      .fix             (fix_bus.arb),
      .dma_wen         (dma_wen),
      .dma_word_lo     (dma_word_lo),
      .dma_word_hi     (dma_word_hi),
      .addr_d          (addr_d),
      .end_addr_d      (end_addr_d),
      .stbuf_req       (stbuf_req),
      .stbuf_addr      (stbuf_addr),
      .stbuf_word      (stbuf_word),
      .stbuf_commit    (stbuf_commit),
      .wren            (dccm_wren),
      .wr_addr_lo      (dccm_wr_addr_lo),
      .wr_addr_hi      (dccm_wr_addr_hi),
      .wr_word_lo      (dccm_wr_word_lo),
      .wr_word_hi      (dccm_wr_word_hi)
   );

endmodule

// File: bench/dccm_ctl_checker.sv
`timescale 1ns/1ps

module dccm_ctl_checker (
   input logic clk,
   input logic reset,
   input logic dccm_wren,
   input logic stbuf_commit,
   input logic dma_wen,
   input logic single_err_r,
   input logic commit_r,
   input logic dma_r
);

   // writers stay quiet once reset has been seen for a full cycle
   assert property (@(posedge clk) (reset && $past(reset)) |-> (!dccm_wren && !stbuf_commit))
      else $error("write port active during reset");

   assert property (@(posedge clk) disable iff (reset) !(stbuf_commit && dma_wen))
      else $error("store buffer committed alongside a DMA write");

   assert property (@(posedge clk) disable iff (reset)
      (single_err_r && (commit_r || dma_r)) |=> dccm_wren)
      else $error("no correction write after a committed single error");

   // other writers may still own the port in that cycle
   assert property (@(posedge clk) disable iff (reset)
      (single_err_r && !(commit_r || dma_r)) |=> (!dccm_wren || dma_wen || stbuf_commit))
      else $error("correction write for a load that neither committed nor was DMA");

endmodule

bind dccm_ctl dccm_ctl_checker i_checker (
   .clk          (clk),
   .reset        (reset),
   .dccm_wren    (dccm_wren),
   .stbuf_commit (stbuf_commit),
   .dma_wen      (dma_wen),
   .single_err_r (single_err_r),
   .commit_r     (commit_r),
   .dma_r        (dma_r)
);

// File: bench/dccm_ctl_tb.sv
`timescale 1ns/1ps
`include "dccm_config.svh"

module dccm_ctl_tb;

   localparam int N_TESTS = 21;

   logic clk = 1'b0;
   logic reset;
   logic valid_d, load_d, store_d, in_dccm_d;
   dccm_pkg::access_size_t size_d;
   dccm_pkg::dccm_addr_t addr_d, end_addr_d, addr_r, end_addr_r, stbuf_addr;
   dccm_pkg::dccm_data_t fwd_data_lo_m, fwd_data_hi_m, sec_data_lo_r, sec_data_hi_r;
   dccm_pkg::dccm_byteen_t fwd_byteen_lo_m, fwd_byteen_hi_m;
   logic load_r, dma_r, commit_r, raw_fwd_lo_r, raw_fwd_hi_r;
   logic single_err_lo_r, single_err_hi_r, double_err_r;
   dccm_pkg::dccm_ecc_t sec_ecc_lo_r, sec_ecc_hi_r;
   logic dma_wen, stbuf_req, stbuf_commit;
   dccm_pkg::dccm_fdata_t dma_word_lo, dma_word_hi, stbuf_word, rd_word_lo, rd_word_hi;
   logic dccm_rden, dccm_wren, rden_r, single_err_r;
   dccm_pkg::dccm_addr_t dccm_rd_addr_lo, dccm_rd_addr_hi, dccm_wr_addr_lo, dccm_wr_addr_hi;
   dccm_pkg::dccm_fdata_t dccm_wr_word_lo, dccm_wr_word_hi;
   dccm_pkg::dccm_data_t ld_data_r, ld_data_corr_r;

   dccm_pkg::dccm_fdata_t mem [0:2**14-1];   // one entry per word address
   logic [31:0] lfsr = 32'hc988;
   int errors = 0;
   int cur_errs = 0;
   int tests_ok = 0;
   int tests_bad = 0;

   dccm_ctl i_dccm_ctl (.*);

   always #5 clk = ~clk;

   // memory model, reads answer one cycle later
   always @(posedge clk) begin
      if (dccm_rden) begin
         rd_word_lo <= mem[dccm_rd_addr_lo[15:2]];
         rd_word_hi <= mem[dccm_rd_addr_hi[15:2]];
      end
      if (dccm_wren) begin
         mem[dccm_wr_addr_lo[15:2]] <= dccm_wr_word_lo;
         mem[dccm_wr_addr_hi[15:2]] <= dccm_wr_word_hi;
      end
   end

   assert property (@(posedge clk) disable iff (reset) rden_r == $past(dccm_rden, 2))
      else begin
         $display("rden_r did not follow dccm_rden by two cycles");
         errors++;
         cur_errs++;
      end

   // taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] expect_load(input logic [63:0] mem_dw, fwd_dw,
                                               input logic [7:0] en, input logic [1:0] off);
      logic [63:0] m;
      for (int i = 0; i < 8; i++) begin
         m[8*i +: 8] = en[i] ? fwd_dw[8*i +: 8] : mem_dw[8*i +: 8];
      end
      m = m >> (8 * off);
      return m[31:0];
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp, act);
      assert (act === exp) else begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         errors++;
         cur_errs++;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %-24s %s", name, cur_errs == 0 ? "ok" : "bad");
      if (cur_errs == 0) tests_ok++;
      else tests_bad++;
      cur_errs = 0;
   endtask

   task automatic next_cycle;
      @(posedge clk);
      #1;
   endtask

   task automatic idle_inputs;
      {valid_d, load_d, store_d, in_dccm_d, size_d, addr_d, end_addr_d} = '0;
      {fwd_data_lo_m, fwd_data_hi_m, fwd_byteen_lo_m, fwd_byteen_hi_m} = '0;
      {load_r, dma_r, commit_r, raw_fwd_lo_r, raw_fwd_hi_r} = '0;
      {single_err_lo_r, single_err_hi_r, double_err_r, addr_r, end_addr_r} = '0;
      {sec_data_lo_r, sec_data_hi_r, sec_ecc_lo_r, sec_ecc_hi_r} = '0;
      {dma_wen, dma_word_lo, dma_word_hi, stbuf_req, stbuf_addr, stbuf_word} = '0;
   endtask

   task automatic drive_d(input logic ld, st, input logic [1:0] sz,
                          input dccm_pkg::dccm_addr_t a, input logic in_d);
      valid_d = 1'b1;
      load_d = ld;
      store_d = st;
      size_d = sz;
      addr_d = a;
      end_addr_d = a + (16'd1 << sz) - 16'd1;
      in_dccm_d = in_d;
   endtask

   task automatic check_rden(input string name, input logic ld, st, input logic [1:0] sz,
                             input dccm_pkg::dccm_addr_t a, input logic in_d, exp);
      drive_d(ld, st, sz, a, in_d);
      #1 check_val({name, " rden"}, 64'(exp), 64'(dccm_rden));
      next_cycle();
      idle_inputs();
      next_cycle();
      check_val({name, " rden_r"}, 64'(exp), 64'(rden_r));
      next_cycle();
      end_test(name);
   endtask

   task automatic run_load(input string name, input dccm_pkg::dccm_addr_t a,
                           input logic [7:0] fen, input logic [63:0] fdat,
                           input logic elo, dbl, raw_lo, commit, contend);
      dccm_pkg::dccm_addr_t end_a;
      logic [63:0] mem_dw, sec_dw;
      logic [31:0] sec_lo;
      logic [6:0] ecc_lo;
      logic fix;
      end_a = a + 16'd3;
      mem_dw = {mem[end_a[15:2]][31:0], mem[a[15:2]][31:0]};
      sec_lo = rand_bits(32);
      ecc_lo = 7'(rand_bits(7));
      sec_dw = {mem_dw[63:32], sec_lo};
      fix = elo & ~raw_lo & ~dbl & commit;
      drive_d(1'b1, 1'b0, `SIZE_WORD, a, 1'b1);
      #1 check_val({name, " rd_addr"}, 64'({end_a, a}),
                   64'({dccm_rd_addr_hi, dccm_rd_addr_lo}));
      next_cycle();
      idle_inputs();
      {fwd_data_hi_m, fwd_data_lo_m} = fdat;
      {fwd_byteen_hi_m, fwd_byteen_lo_m} = fen;
      next_cycle();
      idle_inputs();
      {load_r, commit_r, addr_r, end_addr_r} = {2'b11, a, end_a};
      {single_err_lo_r, double_err_r, raw_fwd_lo_r} = {elo, dbl, raw_lo};
      {sec_data_hi_r, sec_data_lo_r, sec_ecc_lo_r} = {sec_dw, ecc_lo};
      commit_r = commit;
      sec_ecc_hi_r = mem[end_a[15:2]][38:32];
      #1 check_val({name, " rden_r"}, 64'd1, 64'(rden_r));
      check_val({name, " ld_data"}, 64'(expect_load(mem_dw, fdat, fen, a[1:0])),
                64'(ld_data_r));
      check_val({name, " ld_corr"}, 64'(expect_load(sec_dw, fdat, fen, a[1:0])),
                64'(ld_data_corr_r));
      check_val({name, " single_err"}, 64'(elo & ~raw_lo & ~dbl), 64'(single_err_r));
      next_cycle();
      idle_inputs();
      if (contend) begin
         {dma_wen, addr_d} = {1'b1, a ^ 16'h0100};
         dma_word_lo = {7'(rand_bits(7)), rand_bits(32)};
         {stbuf_req, stbuf_addr} = {1'b1, a ^ 16'h0200};
         stbuf_word = {7'(rand_bits(7)), rand_bits(32)};
      end
      #1 check_val({name, " wren"}, 64'(fix | contend), 64'(dccm_wren));
      if (contend) check_val({name, " stbuf_commit"}, 64'd0, 64'(stbuf_commit));
      if (fix) begin
         check_val({name, " wr_addr"}, 64'({a, a}), 64'({dccm_wr_addr_hi, dccm_wr_addr_lo}));
         check_val({name, " wr_word_lo"}, 64'({ecc_lo, sec_lo}), 64'(dccm_wr_word_lo));
         check_val({name, " wr_word_hi"}, 64'({ecc_lo, sec_lo}), 64'(dccm_wr_word_hi));
      end
      next_cycle();
      idle_inputs();
      next_cycle();
      end_test(name);
   endtask

   task automatic dma_vs_stbuf(input string name);
      dccm_pkg::dccm_addr_t a;
      a = 16'(rand_bits(16)) & 16'hfffc;
      {dma_wen, addr_d, end_addr_d} = {1'b1, a, a + 16'd3};
      dma_word_lo = {7'(rand_bits(7)), rand_bits(32)};
      {stbuf_req, stbuf_addr} = {1'b1, a ^ 16'h0040};
      stbuf_word = {7'(rand_bits(7)), rand_bits(32)};
      #1 check_val({name, " stbuf_commit"}, 64'd0, 64'(stbuf_commit));
      check_val({name, " wren"}, 64'd1, 64'(dccm_wren));
      check_val({name, " wr_addr_lo"}, 64'(a), 64'(dccm_wr_addr_lo));
      check_val({name, " wr_word_lo"}, 64'(dma_word_lo), 64'(dccm_wr_word_lo));
      next_cycle();
      idle_inputs();
      next_cycle();
      end_test(name);
   endtask

   task automatic stbuf_with_read(input string name, input dccm_pkg::dccm_addr_t a,
                                  input logic rd, sb_bank);
      logic exp;
      if (rd) drive_d(1'b1, 1'b0, `SIZE_WORD, a, 1'b1);
      stbuf_addr = {13'(rand_bits(13)), sb_bank, 2'b00};
      stbuf_req = 1'b1;
      stbuf_word = {7'(rand_bits(7)), rand_bits(32)};
      exp = !rd || ((sb_bank != addr_d[2]) && (sb_bank != end_addr_d[2]));
      #1 check_val({name, " stbuf_commit"}, 64'(exp), 64'(stbuf_commit));
      if (exp) check_val({name, " wr_addr"}, 64'({stbuf_addr, stbuf_addr}),
                         64'({dccm_wr_addr_hi, dccm_wr_addr_lo}));
      next_cycle();
      idle_inputs();
      repeat (3) next_cycle();
      end_test(name);
   endtask

   initial begin
      #(N_TESTS * 200 * 10);
      $display("watchdog expired before the tests finished");
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      dccm_pkg::dccm_addr_t a;
      for (int i = 0; i < 2**14; i++) begin
         mem[i] = {i[6:0] ^ i[13:7], {i[13:0], 2'b00} * 32'h9e3779b1 ^ 32'h5a5a0000};
      end
      {rd_word_lo, rd_word_hi} = '0;
      idle_inputs();
      reset = 1'b1;
      repeat (16) @(posedge clk);
      #1 reset = 1'b0;
      next_cycle();
      check_rden("rden_load", 1'b1, 1'b0, `SIZE_WORD, 16'h0102, 1'b1, 1'b1);
      check_rden("rden_byte_store", 1'b0, 1'b1, `SIZE_BYTE, 16'h0203, 1'b1, 1'b1);
      check_rden("rden_half_store", 1'b0, 1'b1, `SIZE_HALF, 16'h0302, 1'b1, 1'b1);
      check_rden("rden_word_store", 1'b0, 1'b1, `SIZE_WORD, 16'h0400, 1'b1, 1'b0);
      check_rden("rden_misal_word_store", 1'b0, 1'b1, `SIZE_WORD, 16'h0501, 1'b1, 1'b1);
      check_rden("rden_out_of_dccm", 1'b1, 1'b0, `SIZE_WORD, 16'h0600, 1'b0, 1'b0);
      run_load("load_aligned", 16'(rand_bits(16)) & 16'hfff0, '0, '0, 0, 0, 0, 1, 0);
      for (int k = 1; k < 4; k++) begin
         a = (16'(rand_bits(16)) & 16'hfff0) | k[15:0];
         run_load($sformatf("load_misaligned_%0d", k), a, '0, '0, 0, 0, 0, 1, 0);
      end
      run_load("load_forward", 16'h1232, 8'b0011_0110, {rand_bits(32), rand_bits(32)},
               0, 0, 0, 1, 0);
      run_load("ecc_lo_fix", 16'h2341, 8'b0000_1000, 64'h0, 1, 0, 0, 1, 0);
      run_load("ecc_raw_forwarded", 16'h3450, 8'h0f, {rand_bits(32), rand_bits(32)},
               1, 0, 1, 1, 0);
      run_load("ecc_double", 16'h4560, '0, '0, 1, 1, 0, 1, 0);
      run_load("ecc_no_commit", 16'h5670, '0, '0, 1, 0, 0, 0, 0);
      run_load("fix_beats_dma_stbuf", 16'h6782, '0, '0, 1, 0, 0, 1, 1);
      dma_vs_stbuf("dma_beats_stbuf");
      stbuf_with_read("stbuf_other_bank", 16'h7800, 1'b1, 1'b1);
      stbuf_with_read("stbuf_same_bank", 16'h7900, 1'b1, 1'b0);
      stbuf_with_read("stbuf_split_read", 16'h7a02, 1'b1, 1'b1);
      stbuf_with_read("stbuf_idle", 16'h0000, 1'b0, 1'b0);
      $display("tests ok %0d, bad %0d, errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+logic
logic/dccm_pkg.sv
logic/dccm_fix_if.sv
logic/dccm_rd_pipe.sv
logic/dccm_sec_tracker.sv
logic/dccm_wr_arb.sv
logic/dccm_ctl.sv
bench/dccm_ctl_checker.sv
bench/dccm_ctl_tb.sv

// File: Makefile
# Verilator build and run for the DCCM control testbench

VERILATOR ?= verilator
TOP       ?= dccm_ctl_tb
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

SRCS    := $(filter-out +%,$(shell cat vlog.f))
HEADERS := logic/dccm_config.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): vlog.f $(SRCS) $(HEADERS)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
